/* Makefile */
TOP := exec_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/exec_checker.sv */
// Bound into exec_subsystem_top where it watches the internal write port and register array and needs the top's AW
`timescale 1ns/1ps

module exec_checker
    import exec_uop_pkg::*;
#(
    parameter int AW = 5
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          stall_i,
    input  logic          ready_i,
    input  uop_t          uop_i,
    input  logic          wr_en_i,
    input  logic [AW-1:0] wr_addr_i,
    input  logic [31:0]   wr_word_i,   // Register at the write address
    input  logic [AW-1:0] dbg_raddr_i,
    input  logic [31:0]   dbg_rdata_i
);

    ready_after_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> ready_i)
        else $error("ready_o low in the first cycle after reset");

    // Only a stall or a divide that was just issued may pull ready down
    ready_fall_cause: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(ready_i) |-> stall_i || $past(uop_i.unit == UNIT_DIV))
        else $error("ready_o fell with no stall and no divide issued");

    // A stalled edge leaves the register under the held write address untouched
    no_write_in_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> $stable(wr_word_i))
        else $error("Register changed on an edge where stall_i was high");

    x0_unchanged: assert property (@(posedge clk_i) disable iff (rst_i)
        (wr_en_i && wr_addr_i == '0 && dbg_raddr_i == '0)
            |=> (dbg_raddr_i != '0 || $stable(dbg_rdata_i)))
        else $error("Write to x0 changed the value read from x0");

endmodule

bind exec_subsystem_top exec_checker #(.AW(AW)) u_chk (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stall_i     (stall_i),
    .ready_i     (ready_o),
    .uop_i       (uop_i),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_word_i   (u_rf.regs_q[wr_addr]),
    .dbg_raddr_i (dbg_raddr_i),
    .dbg_rdata_i (dbg_rdata_o)
);

/* bench/exec_tb.sv */
// Expects AW of 5 and a 20 ns clock and leaves the protocol rules to the bound exec_checker
`timescale 1ns/1ps

module exec_tb
    import exec_uop_pkg::*;
    import exec_wb_pkg::*;
();

    localparam int AW        = 5;
    localparam int ALU_CASES = 18;   // Per ALU op, about 200 in all
    localparam int DIV_CASES = 10;   // Per divide op
    localparam int MIX_OPS   = 40;
    localparam int LIMIT     = 200 * 3 + 40 * 40 + MIX_OPS * 60 + 500;

    logic          clk_i;
    logic          rst_i;
    logic          stall_i;
    uop_t          uop_i;
    logic [31:0]   op_a_i;
    logic [31:0]   op_b_i;
    logic [31:0]   pc_next_i;
    logic [AW-1:0] rd_addr_i;
    logic [AW-1:0] dbg_raddr_i;
    logic          ready_o;
    logic          branch_taken_o;
    logic [31:0]   branch_target_o;
    logic [31:0]   dbg_rdata_o;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          stall_rate;     // Percent of cycles with stall_i high
    int          wait_cycles;    // Cycles the last hold waited
    logic [31:0] model [2**AW];  // Expected register contents

    exec_subsystem_top #(.AW(AW)) dut0 (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .uop_i           (uop_i),
        .op_a_i          (op_a_i),
        .op_b_i          (op_b_i),
        .pc_next_i       (pc_next_i),
        .rd_addr_i       (rd_addr_i),
        .dbg_raddr_i     (dbg_raddr_i),
        .ready_o         (ready_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .dbg_rdata_o     (dbg_rdata_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic uop_t make_uop(unit_e unit, logic [3:0] op, logic wr, wb_sel_e sel);
        uop_t u;
        u.unit      = unit;
        u.op        = op;
        u.reg_write = wr;
        u.wb_sel    = sel;
        return u;
    endfunction

    function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return b;   // LUI
        endcase
    endfunction

    function automatic logic branch_model(branch_cond_e c, logic [31:0] a, logic [31:0] b);
        case (c)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return $signed(a) < $signed(b);
            BR_GE:   return $signed(a) >= $signed(b);
            BR_LTU:  return a < b;
            BR_GEU:  return a >= b;
            BR_JAL,
            BR_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] div_model(div_op_e op, logic [31:0] a, logic [31:0] b);
        logic rem;
        logic sgn;
        rem = (op == DIV_REM) || (op == DIV_REMU);
        sgn = (op == DIV_DIV) || (op == DIV_REM);
        if (b == 32'd0) begin
            return rem ? a : 32'hffff_ffff;
        end
        if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return rem ? 32'd0 : a;   // Signed overflow
        end
        if (sgn) begin
            return rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
        end
        return rem ? a % b : a / b;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Called at a falling edge, returns after the edge that accepts the inputs
    task automatic wait_taken();
        logic taken;
        taken       = 1'b0;
        wait_cycles = 0;
        while (!taken) begin
            stall_i = (($urandom % 100) < stall_rate);
            #1;
            taken = ready_o && !stall_i;
            if (!taken) begin
                wait_cycles++;
                @(negedge clk_i);
            end
        end
        @(posedge clk_i);
    endtask

    task automatic run_uop(input uop_t u, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] pc, input logic [AW-1:0] rd,
                           input logic [31:0] value);
        @(negedge clk_i);
        uop_i     = u;
        op_a_i    = a;
        op_b_i    = b;
        pc_next_i = pc;
        rd_addr_i = rd;
        wait_taken();
        if (u.unit == UNIT_DIV) begin
            @(negedge clk_i);
            expect_equal("ready_o", 32'd0, {31'd0, ready_o});
            wait_taken();   // Held until the divider finishes
            if (stall_rate == 0) begin
                expect_equal("ready_o low cycles", 32'd32, wait_cycles);
            end
        end
        if (u.reg_write && rd != '0) begin
            model[rd] = value;
        end
    endtask

    task automatic read_back(input logic [AW-1:0] rd);
        @(negedge clk_i);
        uop_i   = '0;
        stall_i = 1'b0;
        @(negedge clk_i);   // Buffer wrote on the edge in between
        dbg_raddr_i = rd;
        #2;
        expect_equal($sformatf("dbg_rdata_o x%0d", rd), model[rd], dbg_rdata_o);
        dbg_raddr_i = '0;   // Parked on x0 so that x0 writes are watched
    endtask

    task automatic compare_regs();
        @(negedge clk_i);
        uop_i   = '0;
        stall_i = 1'b0;
        for (int r = 0; r < 2**AW; r++) begin
            @(negedge clk_i);
            dbg_raddr_i = AW'(r);
            #2;
            expect_equal($sformatf("dbg_rdata_o x%0d", r), model[AW'(r)], dbg_rdata_o);
        end
        dbg_raddr_i = '0;
    endtask

    initial begin
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   pc;
        logic [AW-1:0] rd;
        logic [3:0]    op;
        void'($urandom(32'h1f81_8fbf));
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        stall_i     = 1'b0;
        uop_i       = '0;
        op_a_i      = '0;
        op_b_i      = '0;
        pc_next_i   = '0;
        rd_addr_i   = '0;
        dbg_raddr_i = '0;
        stall_rate  = 0;
        model       = '{default: 32'd0};
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // First case of each op writes x0, which must stay zero
        for (int k = 0; k <= int'(ALU_PASSB); k++) begin
            for (int i = 0; i < ALU_CASES; i++) begin
                a  = $urandom;
                b  = $urandom;
                rd = (i == 0) ? '0 : AW'(1 + $urandom % (2**AW - 1));
                run_uop(make_uop(UNIT_ALU, 4'(k), 1'b1, WB_RESULT), a, b, 32'd0, rd,
                        alu_model(alu_op_e'(k), a, b));
                read_back(rd);
            end
        end

        for (int c = 0; c <= int'(BR_NONE); c++) begin
            for (int i = 0; i < 4; i++) begin
                @(negedge clk_i);
                a      = $urandom;
                b      = (i == 0) ? a : $urandom;   // Equal operands once
                uop_i  = make_uop(UNIT_BRANCH, 4'(c), 1'b0, WB_RESULT);
                op_a_i = a;
                op_b_i = b;
                #2;
                expect_equal("branch_taken_o", {31'd0, branch_model(branch_cond_e'(c), a, b)},
                             {31'd0, branch_taken_o});
                expect_equal("branch_target_o", (a + b) & ~32'd1, branch_target_o);
            end
        end
        @(negedge clk_i);
        uop_i = make_uop(UNIT_ALU, 4'(BR_JAL), 1'b0, WB_RESULT);   // JAL bits on the ALU
        #2;
        expect_equal("branch_taken_o", 32'd0, {31'd0, branch_taken_o});

        pc = $urandom & ~32'd3;
        rd = AW'(1 + $urandom % (2**AW - 1));
        run_uop(make_uop(UNIT_BRANCH, 4'(BR_JAL), 1'b1, WB_LINK), $urandom, $urandom, pc, rd, pc);
        read_back(rd);

        for (int k = 0; k <= int'(DIV_REMU); k++) begin
            for (int i = 0; i < DIV_CASES; i++) begin
                a = $urandom;
                b = $urandom;
                if (i == 0) begin
                    b = 32'd0;
                end else if (i == 1) begin
                    a = 32'h8000_0000;
                    b = 32'hffff_ffff;
                end else if (i < 5) begin
                    b = b >> b[4:0];   // Small divisors
                end
                rd = AW'(1 + $urandom % (2**AW - 1));
                run_uop(make_uop(UNIT_DIV, 4'(k), 1'b1, WB_RESULT), a, b, 32'd0, rd,
                        div_model(div_op_e'(k), a, b));
                read_back(rd);
            end
        end

        // Few target registers so that a late or repeated write shows up
        stall_rate = 30;
        for (int i = 0; i < MIX_OPS; i++) begin
            a  = $urandom;
            b  = $urandom;
            rd = AW'(1 + $urandom % 7);
            if (($urandom % 4) == 0) begin
                op = 4'($urandom % 4);
                run_uop(make_uop(UNIT_DIV, op, 1'b1, WB_RESULT), a, b, 32'd0, rd,
                        div_model(div_op_e'(op), a, b));
            end else begin
                op = 4'($urandom % 11);
                run_uop(make_uop(UNIT_ALU, op, 1'b1, WB_RESULT), a, b, 32'd0, rd,
                        alu_model(alu_op_e'(op), a, b));
            end
        end
        stall_rate = 0;
        compare_regs();

        // Reset while the divider is busy
        @(negedge clk_i);
        uop_i     = make_uop(UNIT_DIV, 4'(DIV_DIVU), 1'b1, WB_RESULT);
        op_a_i    = $urandom;
        op_b_i    = 32'd7;
        rd_addr_i = AW'(5);
        wait_taken();
        repeat (10) @(negedge clk_i);
        rst_i = 1'b1;
        uop_i = '0;
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;
        #2;
        expect_equal("ready_o", 32'd1, {31'd0, ready_o});
        model = '{default: 32'd0};
        compare_regs();

        repeat (2) @(negedge clk_i);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/exec_wb_pkg.sv
verilog/exec_uop_pkg.sv
verilog/alu_unit.sv
verilog/divide_unit.sv
verilog/execute_stage.sv
verilog/writeback_buffer.sv
verilog/register_file.sv
verilog/exec_subsystem_top.sv
bench/exec_checker.sv
bench/exec_tb.sv

/* verilog/alu_unit.sv */
// Shifts use only b_i[4:0] and PASSB forwards b_i unchanged for LUI
`timescale 1ns/1ps

module alu_unit
    import exec_uop_pkg::*;
(
    input  alu_op_e     op_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic [31:0] result_o,
    output logic        lt_o,
    output logic        ltu_o,
    output logic        eq_o
);

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic [31:0] diff;

    assign shamt = b_i[4:0];
    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;

    // Relations for branch resolution
    assign eq_o  = (a_i == b_i);
    assign ltu_o = (a_i < b_i);
    assign lt_o  = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (op_i)
            ALU_ADD:   result_o = sum;
            ALU_SUB:   result_o = diff;
            ALU_AND:   result_o = a_i & b_i;
            ALU_OR:    result_o = a_i | b_i;
            ALU_XOR:   result_o = a_i ^ b_i;
            ALU_SLL:   result_o = a_i << shamt;
            ALU_SRL:   result_o = a_i >> shamt;
            ALU_SRA:   result_o = $unsigned($signed(a_i) >>> shamt);
            ALU_SLT:   result_o = {31'd0, lt_o};
            ALU_SLTU:  result_o = {31'd0, ltu_o};
            ALU_PASSB: result_o = b_i;
            default:   result_o = sum;   // Unused codes behave as add
        endcase
    end

endmodule

/* verilog/divide_unit.sv */
// Start is ignored while busy and the result stays valid from done until the next start
`timescale 1ns/1ps

module divide_unit
    import exec_uop_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        start_i,
    input  div_op_e     op_i,
    input  logic [31:0] dividend_i,
    input  logic [31:0] divisor_i,
    output logic [31:0] result_o,
    output logic        busy_o,
    output logic        done_o
);

    logic        busy_q;
    logic        done_q;
    logic [4:0]  cnt_q;
    logic [31:0] quo_q;       // Dividend bits shift out, quotient bits shift in
    logic [31:0] rem_q;
    logic [31:0] dvs_q;       // Divisor magnitude
    logic        rem_sel_q;
    logic        neg_quo_q;
    logic        neg_rem_q;

    logic        is_signed;
    logic        a_neg;
    logic        b_neg;
    logic        load;
    logic [32:0] rem_shift;
    logic [32:0] trial;

    assign is_signed = (op_i == DIV_DIV) || (op_i == DIV_REM);
    assign a_neg     = is_signed && dividend_i[31];
    assign b_neg     = is_signed && divisor_i[31];
    assign load      = start_i && !busy_q;

    assign rem_shift = {rem_q, quo_q[31]};
    assign trial     = rem_shift - {1'b0, dvs_q};   // Bit 32 set means restore

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (load) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 5'd1;
                if (cnt_q == 5'd31) begin   // Last of 32 iterations
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            quo_q     <= a_neg ? -dividend_i : dividend_i;
            dvs_q     <= b_neg ? -divisor_i : divisor_i;
            rem_q     <= '0;
            rem_sel_q <= (op_i == DIV_REM) || (op_i == DIV_REMU);
            // Zero divisor leaves the all-ones quotient unsigned
            neg_quo_q <= (a_neg ^ b_neg) && (divisor_i != 32'd0);
            neg_rem_q <= a_neg;   // Remainder takes the dividend sign
        end else if (busy_q) begin
            if (!trial[32]) begin
                rem_q <= trial[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= rem_shift[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // Most negative by minus one falls out of the magnitudes with no extra case
    assign result_o = rem_sel_q ? (neg_rem_q ? -rem_q : rem_q)
                                : (neg_quo_q ? -quo_q : quo_q);
    assign busy_o   = busy_q;
    assign done_o   = done_q;

endmodule

/* verilog/exec_subsystem_top.sv */
// Issue side holds a divide on uop_i until ready_o rises and dbg_raddr_i only observes the registers
`timescale 1ns/1ps

module exec_subsystem_top
    import exec_uop_pkg::*;
    import exec_wb_pkg::*;
#(
    parameter int AW = 5
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          stall_i,
    input  uop_t          uop_i,
    input  logic [31:0]   op_a_i,
    input  logic [31:0]   op_b_i,
    input  logic [31:0]   pc_next_i,
    input  logic [AW-1:0] rd_addr_i,
    input  logic [AW-1:0] dbg_raddr_i,
    output logic          ready_o,
    output logic          branch_taken_o,
    output logic [31:0]   branch_target_o,
    output logic [31:0]   dbg_rdata_o
);

    // Execute to buffer
    logic          res_valid;
    logic [31:0]   res_data;
    wb_ctrl_t      res_ctrl;
    logic [AW-1:0] res_rd;
    logic [31:0]   res_pc_next;

    // Buffer to register file
    logic          wr_en;
    logic [AW-1:0] wr_addr;
    logic [31:0]   wr_data;

    execute_stage #(.AW(AW)) u_exec (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .uop_i           (uop_i),
        .op_a_i          (op_a_i),
        .op_b_i          (op_b_i),
        .pc_next_i       (pc_next_i),
        .rd_addr_i       (rd_addr_i),
        .ready_o         (ready_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .res_valid_o     (res_valid),
        .res_data_o      (res_data),
        .res_ctrl_o      (res_ctrl),
        .res_rd_o        (res_rd),
        .res_pc_next_o   (res_pc_next)
    );

    writeback_buffer #(.AW(AW)) u_wb (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .valid_i   (res_valid),
        .data_i    (res_data),
        .ctrl_i    (res_ctrl),
        .rd_i      (res_rd),
        .pc_next_i (res_pc_next),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data)
    );

    register_file #(.AW(AW)) u_rf (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .dbg_raddr_i (dbg_raddr_i),
        .dbg_rdata_o (dbg_rdata_o)
    );

endmodule

/* verilog/exec_uop_pkg.sv */
// Compile after exec_wb_pkg since the micro-op word carries the writeback select
package exec_uop_pkg;

    typedef enum logic [1:0] {
        UNIT_NONE   = 2'd0,
        UNIT_ALU    = 2'd1,
        UNIT_DIV    = 2'd2,
        UNIT_BRANCH = 2'd3
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASSB = 4'd10   // LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        DIV_DIV  = 4'd0,
        DIV_DIVU = 4'd1,
        DIV_REM  = 4'd2,
        DIV_REMU = 4'd3
    } div_op_e;

    typedef enum logic [3:0] {
        BR_EQ   = 4'd0,
        BR_NE   = 4'd1,
        BR_LT   = 4'd2,
        BR_GE   = 4'd3,
        BR_LTU  = 4'd4,
        BR_GEU  = 4'd5,
        BR_JAL  = 4'd6,
        BR_JALR = 4'd7,
        BR_NONE = 4'd8
    } branch_cond_e;

    // One op field, read according to the unit
    typedef union packed {
        alu_op_e      alu;
        div_op_e      div;
        branch_cond_e br;
    } op_field_u;

    typedef struct packed {
        unit_e                unit;
        op_field_u            op;
        logic                 reg_write;
        exec_wb_pkg::wb_sel_e wb_sel;
    } uop_t;

endpackage

/* verilog/exec_wb_pkg.sv */
// Writeback select is two bits wide and WB_LINK always writes the pc_next value
package exec_wb_pkg;

    // Source of the value written to rd
    typedef enum logic [1:0] {
        WB_RESULT = 2'd0,   // Unit result
        WB_LINK   = 2'd1    // Return address for JAL and JALR
    } wb_sel_e;

    typedef struct packed {
        logic    reg_write;
        wb_sel_e wb_sel;
    } wb_ctrl_t;

endpackage

/* verilog/execute_stage.sv */
// Branches compare op_a_i with op_b_i and target their sum, and a divide must stay on uop_i until ready_o rises
`timescale 1ns/1ps

module execute_stage
    import exec_uop_pkg::*;
    import exec_wb_pkg::*;
#(
    parameter int AW = 5
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          stall_i,
    input  uop_t          uop_i,
    input  logic [31:0]   op_a_i,
    input  logic [31:0]   op_b_i,
    input  logic [31:0]   pc_next_i,
    input  logic [AW-1:0] rd_addr_i,
    output logic          ready_o,
    output logic          branch_taken_o,
    output logic [31:0]   branch_target_o,
    output logic          res_valid_o,
    output logic [31:0]   res_data_o,
    output wb_ctrl_t      res_ctrl_o,
    output logic [AW-1:0] res_rd_o,
    output logic [31:0]   res_pc_next_o
);

    alu_op_e     alu_op;
    logic [31:0] alu_res;
    logic        lt;
    logic        ltu;
    logic        eq;
    logic [31:0] div_res;
    logic        div_busy;
    logic        div_done;
    logic        div_start;
    logic        div_pend_q;   // Divide issued, result not yet taken
    logic        div_held_q;   // Done arrived under stall
    logic        div_fin;
    logic        div_wait;
    logic        is_div;
    logic        cond;

    assign is_div = (uop_i.unit == UNIT_DIV);
    assign alu_op = (uop_i.unit == UNIT_ALU) ? uop_i.op.alu : ALU_ADD;   // Adder for targets

    alu_unit u_alu (
        .op_i     (alu_op),
        .a_i      (op_a_i),
        .b_i      (op_b_i),
        .result_o (alu_res),
        .lt_o     (lt),
        .ltu_o    (ltu),
        .eq_o     (eq)
    );

    assign div_start = is_div && !div_pend_q && !stall_i;

    divide_unit u_div (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .op_i       (uop_i.op.div),
        .dividend_i (op_a_i),
        .divisor_i  (op_b_i),
        .result_o   (div_res),
        .busy_o     (div_busy),
        .done_o     (div_done)
    );

    assign div_fin  = div_done || div_held_q;
    assign div_wait = div_busy || (div_pend_q && !div_fin);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            div_pend_q <= 1'b0;
            div_held_q <= 1'b0;
        end else begin
            if (div_start) begin
                div_pend_q <= 1'b1;
            end else if (div_fin && !stall_i) begin
                div_pend_q <= 1'b0;
            end
            div_held_q <= div_pend_q && div_fin && stall_i;
        end
    end

    assign ready_o = !stall_i && !div_wait;

    always_comb begin
        case (uop_i.op.br)
            BR_EQ:   cond = eq;
            BR_NE:   cond = !eq;
            BR_LT:   cond = lt;
            BR_GE:   cond = !lt;
            BR_LTU:  cond = ltu;
            BR_GEU:  cond = !ltu;
            BR_JAL,
            BR_JALR: cond = 1'b1;
            default: cond = 1'b0;   // BR_NONE never redirects
        endcase
    end

    assign branch_taken_o  = (uop_i.unit == UNIT_BRANCH) && cond;
    assign branch_target_o = {alu_res[31:1], 1'b0};

    // Single-cycle units are valid at once, a divide only when it finishes
    assign res_valid_o   = div_pend_q ? div_fin
                                      : (uop_i.unit == UNIT_ALU) || (uop_i.unit == UNIT_BRANCH);
    assign res_data_o    = is_div ? div_res : alu_res;
    assign res_ctrl_o    = wb_ctrl_t'{reg_write: uop_i.reg_write, wb_sel: uop_i.wb_sel};
    assign res_rd_o      = rd_addr_i;
    assign res_pc_next_o = pc_next_i;

endmodule

/* verilog/register_file.sv */
// Register x0 ignores writes and the whole array clears while rst_i is high
`timescale 1ns/1ps

module register_file #(
    parameter int AW = 5
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          wr_en_i,
    input  logic [AW-1:0] wr_addr_i,
    input  logic [31:0]   wr_data_i,
    input  logic [AW-1:0] dbg_raddr_i,
    output logic [31:0]   dbg_rdata_o
);

    logic [31:0] regs_q [2**AW];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 2**AW; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    assign dbg_rdata_o = regs_q[dbg_raddr_i];   // Combinational read

endmodule

/* verilog/writeback_buffer.sv */
// A write held by stall_i is issued once on the first edge after stall_i drops
`timescale 1ns/1ps

module writeback_buffer
    import exec_wb_pkg::*;
#(
    parameter int AW = 5
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          stall_i,
    input  logic          valid_i,
    input  logic [31:0]   data_i,
    input  wb_ctrl_t      ctrl_i,
    input  logic [AW-1:0] rd_i,
    input  logic [31:0]   pc_next_i,
    output logic          wr_en_o,
    output logic [AW-1:0] wr_addr_o,
    output logic [31:0]   wr_data_o
);

    logic          wr_en_q;
    logic [AW-1:0] wr_addr_q;
    logic [31:0]   wr_data_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_en_q <= 1'b0;
        end else if (!stall_i) begin
            wr_en_q <= valid_i && ctrl_i.reg_write;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            wr_addr_q <= rd_i;
            wr_data_q <= (ctrl_i.wb_sel == WB_LINK) ? pc_next_i : data_i;   // Link mux
        end
    end

    assign wr_en_o   = wr_en_q && !stall_i;   // No write while stalled
    assign wr_addr_o = wr_addr_q;
    assign wr_data_o = wr_data_q;

endmodule
